/* collide_pkg.sv */
`include "collide_settings.svh"

package collide_pkg;

	// signed Q16.16
	typedef logic signed [`COLLIDE_WORD-1:0] fixed_t;

	typedef struct packed {
		fixed_t x;
		fixed_t y;
		fixed_t z;
	} vec3_t;

	typedef enum logic [1:0] {
		KIND_MISS       = 2'd0,
		KIND_DEGENERATE = 2'd1,
		KIND_CONTACT    = 2'd2
	} contact_kind_t;

	// ==============================
	// stage payloads
	// ==============================

	// separation result, diff is p1 - p2
	typedef struct packed {
		vec3_t  p1;
		vec3_t  diff;
		fixed_t r1;
		fixed_t r2;
		fixed_t d;
	} sep_payload_t;

	// classification result
	typedef struct packed {
		contact_kind_t kind;
		vec3_t         p1;
		vec3_t         diff;
		fixed_t        d;
		fixed_t        depth;
		fixed_t        k;
	} class_payload_t;

	// normalization result
	typedef struct packed {
		contact_kind_t kind;
		vec3_t         p1;
		vec3_t         normal;
		fixed_t        depth;
		fixed_t        k;
	} norm_payload_t;

endpackage

/* collide_settings.svh */
`ifndef COLLIDE_SETTINGS_SVH
`define COLLIDE_SETTINGS_SVH

// ==============================
// number format
// ==============================

// one fixed-point value, signed Q16.16
`define COLLIDE_WORD 32

// fraction bits of a value
`define COLLIDE_FRAC 16

// squares and divider dividends
`define COLLIDE_WIDE 64

// ==============================
// iteration counts
// ==============================

// one result bit per step, 64-bit radicand gives 32 bits
`define COLLIDE_SQRT_STEPS 32

// quotient bits per normal component
`define COLLIDE_DIV_STEPS 48

`endif

/* collide_vectors.txt */
// x1 y1 z1 r1 x2 y2 z2 r2 | hit cx cy cz nx ny nz depth, all Q16.16 hex except hit
// separated, 3-4-5 contacts, near miss, coincident centres, touching, fractional k
00000000 00000000 00000000 00020000 000A0000 00000000 00000000 00030000  00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00030000 00030000 00040000 00000000 00040000  00000001 00013332 00019998 00000000 FFFF6667 FFFF3334 00000000 00020000
00000000 00000000 00000000 00020000 00000000 00000000 00050000 0002FFFF  00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00050000 00000000 00000000 00020000 00020000 00000000 00000000 00020000  00000001 00038000 00000000 00000000 00010000 00000000 00000000 00010000
FF9C0000 FF9C0000 FF9C0000 00010000 00640000 00640000 00640000 00010000  00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00010000 00020000 00030000 00010000 00010000 00020000 00030000 00028000  00000001 00010000 00020000 00030000 00010000 00000000 00000000 00038000
00000000 00000000 00000000 00020000 00000000 00030000 00040000 00030000  00000001 00000000 00013332 00019998 00000000 FFFF6667 FFFF3334 00000000
00010000 00010000 00010000 00010000 00010000 00010000 00048000 00010000  00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
000A0000 00140000 001E0000 00040000 000A0000 00100000 001B0000 00030000  00000001 000A0000 0011999C 001C3335 00000000 0000CCCC 00009999 00020000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000  00000001 00000000 00000000 00000000 00010000 00000000 00000000 00000000
FFFF0000 FFFF0000 FFFF0000 00040000 00010000 00020000 00050000 00050000  00000001 FFFFDB6C 00004922 00019247 FFFFB6DC FFFF924A FFFF2493 00020000
00000000 00000000 00000000 00030000 00040000 00030000 00000000 00028000  00000001 00023331 0001A664 00000000 FFFF3334 FFFF6667 00000000 00008000
FFFD8000 00000000 00070000 00008000 FFFD8000 00000000 00070000 00004000  00000001 FFFD8000 00000000 00070000 00010000 00000000 00000000 0000C000
00040000 FFFD0000 00000000 00010000 00000000 00000000 00000000 00078000  00000001 00049999 FFFC8CCD 00000000 0000CCCC FFFF6667 00000000 00038000
00000000 00000000 FFFF0000 00020000 00000000 00000000 00018000 00010000  00000001 00000000 00000000 0000C000 00000000 00000000 FFFF0000 00008000

/* contact_classify.sv */
`include "collide_settings.svh"

module contact_classify (
	input  logic                        clk,
	input  logic                        CLK_d,
	input  logic                        in_valid,
	output logic                        in_ready,
	input  collide_pkg::sep_payload_t   in_data,
	output logic                        out_valid,
	input  logic                        out_ready,
	output collide_pkg::class_payload_t out_data
);

	logic                       accept;
	collide_pkg::fixed_t        rsum;
	collide_pkg::fixed_t        overlap;
	collide_pkg::fixed_t        offset;
	collide_pkg::contact_kind_t kind;

	assign accept   = in_valid && in_ready;
	assign in_ready = !out_valid || out_ready;

	// r1+r2, r1+r2-d and r2-r1-d
	assign rsum    = in_data.r1 + in_data.r2;
	assign overlap = rsum - in_data.d;
	assign offset  = in_data.r2 - in_data.r1 - in_data.d;

	// the miss test wins over the degenerate case
	always_comb
	begin
		if (in_data.d > rsum)
			kind = collide_pkg::KIND_MISS;
		else if (in_data.d == '0)
			kind = collide_pkg::KIND_DEGENERATE;
		else
			kind = collide_pkg::KIND_CONTACT;
	end

	always_ff @(posedge clk or posedge CLK_d)
	begin
		if (CLK_d)
			out_valid <= 1'b0;
		else if (accept)
			out_valid <= 1'b1;
		else if (out_ready)
			out_valid <= 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			out_data.kind <= kind;
			out_data.p1   <= in_data.p1;
			out_data.diff <= in_data.diff;
			out_data.d    <= in_data.d;
			// half offset, arithmetic shift
			out_data.k    <= offset >>> 1;
			case (kind)
				collide_pkg::KIND_DEGENERATE: out_data.depth <= rsum;
				collide_pkg::KIND_CONTACT:    out_data.depth <= overlap;
				default:                      out_data.depth <= '0;
			endcase
		end
	end

endmodule

/* contact_normalize.sv */
`include "collide_settings.svh"

module contact_normalize (
	input  logic                        clk,
	input  logic                        CLK_d,
	input  logic                        in_valid,
	output logic                        in_ready,
	input  collide_pkg::class_payload_t in_data,
	output logic                        out_valid,
	input  logic                        out_ready,
	output collide_pkg::norm_payload_t  out_data
);

	localparam int STEP_W = $clog2(`COLLIDE_DIV_STEPS);
	localparam int REM_W  = `COLLIDE_WORD + 1;
	localparam logic [STEP_W-1:0] LAST_STEP = STEP_W'(`COLLIDE_DIV_STEPS - 1);
	localparam collide_pkg::fixed_t FIX_ONE = 1 << `COLLIDE_FRAC;

	typedef enum logic [1:0] {
		S_IDLE,
		S_DIV,
		S_OUT
	} norm_state_t;

	norm_state_t              state;
	logic [STEP_W-1:0]        step;
	logic [1:0]               comp;
	logic                     accept;
	collide_pkg::vec3_t       held_diff;
	logic [`COLLIDE_WORD-1:0] divisor;
	logic [`COLLIDE_WIDE-1:0] num;
	logic [`COLLIDE_WIDE-1:0] num_next;
	logic [REM_W-1:0]         rem;
	logic [REM_W-1:0]         rem_shift;
	logic                     qbit;
	logic [`COLLIDE_WORD-1:0] quot_mag;
	collide_pkg::fixed_t      cur_diff;
	collide_pkg::fixed_t      next_diff;
	collide_pkg::fixed_t      quot;

	// |v| shifted up by the fraction bits
	function automatic logic [`COLLIDE_WIDE-1:0] dividend_of(input collide_pkg::fixed_t v);
		logic [`COLLIDE_WORD-1:0] mag;
		mag = v[`COLLIDE_WORD-1] ? -v : v;
		return `COLLIDE_WIDE'(mag) << `COLLIDE_FRAC;
	endfunction

	assign accept    = in_valid && in_ready;
	assign in_ready  = (state == S_IDLE);
	assign out_valid = (state == S_OUT);

	// component under division, then the one loaded after it
	always_comb
	begin
		case (comp)
			2'd0:    cur_diff = held_diff.x;
			2'd1:    cur_diff = held_diff.y;
			default: cur_diff = held_diff.z;
		endcase
	end
	assign next_diff = (comp == 2'd0) ? held_diff.y : held_diff.z;

	// ==============================
	// restoring divider step
	// ==============================
	assign rem_shift = {rem[REM_W-2:0], num[`COLLIDE_DIV_STEPS-1]};
	assign qbit      = (rem_shift >= {1'b0, divisor});
	assign num_next  = {num[`COLLIDE_WIDE-2:0], qbit};
	assign quot_mag  = num_next[`COLLIDE_WORD-1:0];
	assign quot      = cur_diff[`COLLIDE_WORD-1] ? -quot_mag : quot_mag;

	always_ff @(posedge clk or posedge CLK_d)
	begin
		if (CLK_d)
		begin
			state <= S_IDLE;
			step  <= '0;
			comp  <= '0;
		end
		else
		begin
			case (state)
				S_IDLE:
					if (accept)
					begin
						step  <= '0;
						comp  <= '0;
						state <= (in_data.kind == collide_pkg::KIND_CONTACT) ? S_DIV : S_OUT;
					end
				S_DIV:
					if (step == LAST_STEP)
					begin
						step <= '0;
						if (comp == 2'd2)
							state <= S_OUT;
						else
							comp <= comp + 1'b1;
					end
					else
					begin
						step <= step + 1'b1;
					end
				S_OUT:
					if (out_ready)
						state <= S_IDLE;
				default:
					state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			out_data.kind  <= in_data.kind;
			out_data.p1    <= in_data.p1;
			out_data.depth <= in_data.depth;
			out_data.k     <= in_data.k;
			if (in_data.kind == collide_pkg::KIND_DEGENERATE)
				out_data.normal <= '{x: FIX_ONE, y: '0, z: '0};
			else
				out_data.normal <= '0;
			held_diff <= in_data.diff;
			divisor   <= in_data.d;
			num       <= dividend_of(in_data.diff.x);
			rem       <= '0;
		end
		else if (state == S_DIV)
		begin
			if (step == LAST_STEP)
			begin
				case (comp)
					2'd0:    out_data.normal.x <= quot;
					2'd1:    out_data.normal.y <= quot;
					default: out_data.normal.z <= quot;
				endcase
				num <= dividend_of(next_diff);
				rem <= '0;
			end
			else
			begin
				num <= num_next;
				rem <= qbit ? rem_shift - {1'b0, divisor} : rem_shift;
			end
		end
	end

	// classification only sends contacts with d above zero
	divisor_nonzero: assert property (@(posedge clk) disable iff (CLK_d)
		state == S_DIV |-> divisor != '0);

endmodule

/* contact_point.sv */
`include "collide_settings.svh"

module contact_point (
	input  logic                       clk,
	input  logic                       CLK_d,
	input  logic                       in_valid,
	output logic                       in_ready,
	input  collide_pkg::norm_payload_t in_data,
	output logic                       out_valid,
	input  logic                       out_ready,
	output logic                       hit,
	output collide_pkg::vec3_t         pos,
	output collide_pkg::vec3_t         normal,
	output collide_pkg::fixed_t        depth
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_MUL,
		S_OUT
	} point_state_t;

	point_state_t                    state;
	logic                            accept;
	logic signed [`COLLIDE_WIDE-1:0] prod_x;
	logic signed [`COLLIDE_WIDE-1:0] prod_y;
	logic signed [`COLLIDE_WIDE-1:0] prod_z;
	collide_pkg::vec3_t              nk_q;
	collide_pkg::vec3_t              p1_q;
	collide_pkg::vec3_t              normal_q;
	collide_pkg::fixed_t             depth_q;
	collide_pkg::contact_kind_t      kind_q;

	assign accept    = in_valid && in_ready;
	assign in_ready  = (state == S_IDLE);
	assign out_valid = (state == S_OUT);

	// n*k in Q32.32
	assign prod_x = in_data.normal.x * in_data.k;
	assign prod_y = in_data.normal.y * in_data.k;
	assign prod_z = in_data.normal.z * in_data.k;

	always_ff @(posedge clk or posedge CLK_d)
	begin
		if (CLK_d)
			state <= S_IDLE;
		else
		begin
			case (state)
				S_IDLE:  if (accept) state <= S_MUL;
				S_MUL:   state <= S_OUT;
				S_OUT:   if (out_ready) state <= S_IDLE;
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		// first cycle, scale back to Q16.16
		if (accept)
		begin
			nk_q.x   <= prod_x[`COLLIDE_FRAC +: `COLLIDE_WORD];
			nk_q.y   <= prod_y[`COLLIDE_FRAC +: `COLLIDE_WORD];
			nk_q.z   <= prod_z[`COLLIDE_FRAC +: `COLLIDE_WORD];
			p1_q     <= in_data.p1;
			normal_q <= in_data.normal;
			depth_q  <= in_data.depth;
			kind_q   <= in_data.kind;
		end
		// second cycle, add p1 and pick the result
		if (state == S_MUL)
		begin
			case (kind_q)
				collide_pkg::KIND_CONTACT:
				begin
					hit    <= 1'b1;
					pos    <= '{x: p1_q.x + nk_q.x, y: p1_q.y + nk_q.y, z: p1_q.z + nk_q.z};
					normal <= normal_q;
					depth  <= depth_q;
				end
				collide_pkg::KIND_DEGENERATE:
				begin
					hit    <= 1'b1;
					pos    <= p1_q;
					normal <= normal_q;
					depth  <= depth_q;
				end
				default:
				begin
					hit    <= 1'b0;
					pos    <= '0;
					normal <= '0;
					depth  <= '0;
				end
			endcase
		end
	end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# builds the sphere contact testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	-f verilog.f \
	--top-module tb_sphere_collide \
	-o sim_tb
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

output=$(./obj_dir/sim_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "TEST OK"; then
	exit 0
fi
echo "pass message not found"
exit 1

/* sphere_collide_top.sv */
`include "collide_settings.svh"

module sphere_collide_top (
	input  logic                     clk,
	input  logic                     CLK_d,
	input  logic                     in_valid,
	output logic                     in_ready,
	input  logic [`COLLIDE_WORD-1:0] x1,
	input  logic [`COLLIDE_WORD-1:0] y1,
	input  logic [`COLLIDE_WORD-1:0] z1,
	input  logic [`COLLIDE_WORD-1:0] r1,
	input  logic [`COLLIDE_WORD-1:0] x2,
	input  logic [`COLLIDE_WORD-1:0] y2,
	input  logic [`COLLIDE_WORD-1:0] z2,
	input  logic [`COLLIDE_WORD-1:0] r2,
	output logic                     out_valid,
	input  logic                     out_ready,
	output logic                     hit,
	output logic [`COLLIDE_WORD-1:0] cx,
	output logic [`COLLIDE_WORD-1:0] cy,
	output logic [`COLLIDE_WORD-1:0] cz,
	output logic [`COLLIDE_WORD-1:0] nx,
	output logic [`COLLIDE_WORD-1:0] ny,
	output logic [`COLLIDE_WORD-1:0] nz,
	output logic [`COLLIDE_WORD-1:0] depth
);

	collide_pkg::vec3_t          p1;
	collide_pkg::vec3_t          p2;
	collide_pkg::vec3_t          pos;
	collide_pkg::vec3_t          normal;
	collide_pkg::sep_payload_t   sep_data;
	collide_pkg::sep_payload_t   sep_buf_data;
	collide_pkg::class_payload_t class_data;
	collide_pkg::class_payload_t class_buf_data;
	collide_pkg::norm_payload_t  norm_data;
	collide_pkg::norm_payload_t  norm_buf_data;
	logic                        sep_valid;
	logic                        sep_ready;
	logic                        sep_buf_valid;
	logic                        sep_buf_ready;
	logic                        class_valid;
	logic                        class_ready;
	logic                        class_buf_valid;
	logic                        class_buf_ready;
	logic                        norm_valid;
	logic                        norm_ready;
	logic                        norm_buf_valid;
	logic                        norm_buf_ready;

	assign p1 = '{x: x1, y: y1, z: z1};
	assign p2 = '{x: x2, y: y2, z: z2};

	// ==============================
	// pipeline
	// ==============================
	sphere_separation u_sep (
		.clk(clk), .CLK_d(CLK_d),
		.in_valid(in_valid), .in_ready(in_ready),
		.p1(p1), .p2(p2), .r1(r1), .r2(r2),
		.out_valid(sep_valid), .out_ready(sep_ready), .out_data(sep_data)
	);

	stage_buffer #(.payload_t(collide_pkg::sep_payload_t)) u_sep_buf (
		.clk(clk), .CLK_d(CLK_d),
		.in_valid(sep_valid), .in_ready(sep_ready), .in_data(sep_data),
		.out_valid(sep_buf_valid), .out_ready(sep_buf_ready), .out_data(sep_buf_data)
	);

	contact_classify u_classify (
		.clk(clk), .CLK_d(CLK_d),
		.in_valid(sep_buf_valid), .in_ready(sep_buf_ready), .in_data(sep_buf_data),
		.out_valid(class_valid), .out_ready(class_ready), .out_data(class_data)
	);

	stage_buffer #(.payload_t(collide_pkg::class_payload_t)) u_class_buf (
		.clk(clk), .CLK_d(CLK_d),
		.in_valid(class_valid), .in_ready(class_ready), .in_data(class_data),
		.out_valid(class_buf_valid), .out_ready(class_buf_ready), .out_data(class_buf_data)
	);

	contact_normalize u_normalize (
		.clk(clk), .CLK_d(CLK_d),
		.in_valid(class_buf_valid), .in_ready(class_buf_ready), .in_data(class_buf_data),
		.out_valid(norm_valid), .out_ready(norm_ready), .out_data(norm_data)
	);

	stage_buffer #(.payload_t(collide_pkg::norm_payload_t)) u_norm_buf (
		.clk(clk), .CLK_d(CLK_d),
		.in_valid(norm_valid), .in_ready(norm_ready), .in_data(norm_data),
		.out_valid(norm_buf_valid), .out_ready(norm_buf_ready), .out_data(norm_buf_data)
	);

	contact_point u_point (
		.clk(clk), .CLK_d(CLK_d),
		.in_valid(norm_buf_valid), .in_ready(norm_buf_ready), .in_data(norm_buf_data),
		.out_valid(out_valid), .out_ready(out_ready),
		.hit(hit), .pos(pos), .normal(normal), .depth(depth)
	);

	// result fields
	assign cx = pos.x;
	assign cy = pos.y;
	assign cz = pos.z;
	assign nx = normal.x;
	assign ny = normal.y;
	assign nz = normal.z;

endmodule

/* sphere_separation.sv */
`include "collide_settings.svh"

module sphere_separation (
	input  logic                      clk,
	input  logic                      CLK_d,
	input  logic                      in_valid,
	output logic                      in_ready,
	input  collide_pkg::vec3_t        p1,
	input  collide_pkg::vec3_t        p2,
	input  collide_pkg::fixed_t       r1,
	input  collide_pkg::fixed_t       r2,
	output logic                      out_valid,
	input  logic                      out_ready,
	output collide_pkg::sep_payload_t out_data
);

	localparam int STEP_W = $clog2(`COLLIDE_SQRT_STEPS + 1);
	localparam int REM_W  = `COLLIDE_WORD + 4;
	localparam logic [STEP_W-1:0] LAST = STEP_W'(`COLLIDE_SQRT_STEPS);

	typedef enum logic [1:0] {
		S_IDLE,
		S_ROOT,
		S_OUT
	} sep_state_t;

	sep_state_t                      state;
	logic [STEP_W-1:0]               step;
	logic                            accept;
	collide_pkg::vec3_t              diff;
	logic signed [`COLLIDE_WIDE-1:0] dx;
	logic signed [`COLLIDE_WIDE-1:0] dy;
	logic signed [`COLLIDE_WIDE-1:0] dz;
	logic [`COLLIDE_WIDE-1:0]        sum_sq;
	logic [`COLLIDE_WIDE-1:0]        radicand;
	logic [REM_W-1:0]                rem;
	logic [REM_W-1:0]                rem_shift;
	logic [REM_W-1:0]                trial;
	logic [`COLLIDE_WORD-1:0]        root;
	logic                            take;

	assign accept    = in_valid && in_ready;
	assign in_ready  = (state == S_IDLE);
	assign out_valid = (state == S_OUT);

	assign diff = '{x: p1.x - p2.x, y: p1.y - p2.y, z: p1.z - p2.z};

	// squares of Q16.16 are Q32.32, so the root lands in Q16.16
	assign dx     = diff.x;
	assign dy     = diff.y;
	assign dz     = diff.z;
	assign sum_sq = dx * dx + dy * dy + dz * dz;

	// ==============================
	// digit-by-digit square root
	// ==============================
	assign rem_shift = {rem[REM_W-3:0], radicand[`COLLIDE_WIDE-1 -: 2]};
	assign trial     = {2'b00, root, 2'b01};
	assign take      = (rem_shift >= trial);

	always_ff @(posedge clk or posedge CLK_d)
	begin
		if (CLK_d)
		begin
			state <= S_IDLE;
			step  <= '0;
		end
		else
		begin
			case (state)
				S_IDLE:
					if (accept)
					begin
						state <= S_ROOT;
						step  <= '0;
					end
				S_ROOT:
					if (step == LAST)
						state <= S_OUT;
					else
						step <= step + 1'b1;
				S_OUT:
					if (out_ready)
						state <= S_IDLE;
				default:
					state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			out_data.p1   <= p1;
			out_data.diff <= diff;
			out_data.r1   <= r1;
			out_data.r2   <= r2;
			radicand      <= sum_sq;
			rem           <= '0;
			root          <= '0;
		end
		else if (state == S_ROOT)
		begin
			if (step != LAST)
			begin
				radicand <= radicand << 2;
				rem      <= take ? rem_shift - trial : rem_shift;
				root     <= {root[`COLLIDE_WORD-2:0], take};
			end
			else
			begin
				out_data.d <= root;
			end
		end
	end

	step_bound: assert property (@(posedge clk) disable iff (CLK_d)
		step <= LAST);

endmodule

/* stage_buffer.sv */
module stage_buffer #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     CLK_d,
	input  logic     in_valid,
	output logic     in_ready,
	input  payload_t in_data,
	output logic     out_valid,
	input  logic     out_ready,
	output payload_t out_data
);

	logic full;

	// accept when empty or when the entry leaves this cycle
	assign in_ready  = !full || out_ready;
	assign out_valid = full;

	always_ff @(posedge clk or posedge CLK_d)
	begin
		if (CLK_d)
			full <= 1'b0;
		else if (in_valid && in_ready)
			full <= 1'b1;
		else if (out_ready)
			full <= 1'b0;
	end

	// the held entry
	always_ff @(posedge clk)
	begin
		if (in_valid && in_ready)
			out_data <= in_data;
	end

	held_stable: assert property (@(posedge clk) disable iff (CLK_d)
		out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

/* tb_sphere_collide.sv */
`include "collide_settings.svh"

module tb_sphere_collide;

	localparam int ROWS            = 15;
	localparam int COLS            = 16;
	localparam int INPUTS          = 8;
	localparam int FIELDS          = 8;
	localparam int WATCHDOG_CYCLES = ROWS * 200 + 1000;

	typedef logic [`COLLIDE_WORD-1:0] word_t;

	logic   clk = 1'b0;
	logic   CLK_d;
	logic   in_valid;
	logic   in_ready;
	word_t  x1;
	word_t  y1;
	word_t  z1;
	word_t  r1;
	word_t  x2;
	word_t  y2;
	word_t  z2;
	word_t  r2;
	logic   out_valid;
	logic   out_ready;
	logic   hit;
	word_t  cx;
	word_t  cy;
	word_t  cz;
	word_t  nx;
	word_t  ny;
	word_t  nz;
	word_t  depth;

	word_t  vec_mem [0:ROWS*COLS-1];
	word_t  held_word [0:FIELDS-1];
	int     pending [$];
	int     errors = 0;
	int     checks = 0;
	int     results_seen = 0;
	logic   holding = 1'b0;
	integer seed;

	always #10 clk = ~clk;

	sphere_collide_top UUT (
		.clk(clk), .CLK_d(CLK_d),
		.in_valid(in_valid), .in_ready(in_ready),
		.x1(x1), .y1(y1), .z1(z1), .r1(r1),
		.x2(x2), .y2(y2), .z2(z2), .r2(r2),
		.out_valid(out_valid), .out_ready(out_ready),
		.hit(hit), .cx(cx), .cy(cy), .cz(cz),
		.nx(nx), .ny(ny), .nz(nz), .depth(depth)
	);

	// ==============================
	// helpers
	// ==============================
	function automatic word_t bit_word(input logic b);
		return {{(`COLLIDE_WORD-1){1'b0}}, b};
	endfunction

	// same order as the expected columns of a row
	function automatic word_t result_field(input int idx);
		case (idx)
			0:       return bit_word(hit);
			1:       return cx;
			2:       return cy;
			3:       return cz;
			4:       return nx;
			5:       return ny;
			6:       return nz;
			default: return depth;
		endcase
	endfunction

	function automatic string field_name(input int idx);
		case (idx)
			0:       return "hit";
			1:       return "cx";
			2:       return "cy";
			3:       return "cz";
			4:       return "nx";
			5:       return "ny";
			6:       return "nz";
			default: return "depth";
		endcase
	endfunction

	task automatic check_field(input string name, input word_t got, input word_t expected);
		checks++;
		assert (got == expected)
		else
		begin
			$display("CHECK FAILED at time %0t: %s is %h, expected %h", $time, name, got, expected);
			errors++;
		end
	endtask

	task automatic apply_row(input int row);
		int base;
		base = row * COLS;
		x1       <= vec_mem[base];
		y1       <= vec_mem[base+1];
		z1       <= vec_mem[base+2];
		r1       <= vec_mem[base+3];
		x2       <= vec_mem[base+4];
		y2       <= vec_mem[base+5];
		z2       <= vec_mem[base+6];
		r2       <= vec_mem[base+7];
		in_valid <= 1'b1;
	endtask

	// one row at a time, held until the handshake
	task automatic send_rows();
		logic taken;
		@(posedge clk);
		for (int row = 0; row < ROWS; row++)
		begin
			apply_row(row);
			taken = 1'b0;
			while (!taken)
			begin
				@(negedge clk);
				taken = in_ready;
				@(posedge clk);
			end
			pending.push_back(row);
		end
		in_valid <= 1'b0;
	endtask

	task automatic take_result();
		int row;
		assert (pending.size() > 0)
		else
		begin
			$display("a result arrived at time %0t with no row outstanding", $time);
			errors++;
		end
		if (pending.size() > 0)
		begin
			row = pending.pop_front();
			for (int i = 0; i < FIELDS; i++)
				check_field(field_name(i), result_field(i), vec_mem[row*COLS+INPUTS+i]);
		end
		results_seen++;
	endtask

	task automatic hold_result();
		for (int i = 0; i < FIELDS; i++)
			held_word[i] = result_field(i);
	endtask

	task automatic check_held();
		assert (out_valid)
		else
		begin
			$display("out_valid dropped at time %0t while a result was held", $time);
			errors++;
		end
		for (int i = 0; i < FIELDS; i++)
		begin
			checks++;
			assert (result_field(i) == held_word[i])
			else
			begin
				$display("%s changed at time %0t while the result was held", field_name(i), $time);
				errors++;
			end
		end
	endtask

	// ==============================
	// processes
	// ==============================
	initial
	begin
		CLK_d    = 1'b1;
		in_valid = 1'b0;
		x1       = '0;
		y1       = '0;
		z1       = '0;
		r1       = '0;
		x2       = '0;
		y2       = '0;
		z2       = '0;
		r2       = '0;
		$readmemh("collide_vectors.txt", vec_mem);
		repeat (16) @(posedge clk);
		CLK_d <= 1'b0;
		@(negedge clk);
		check_field("out_valid after reset", bit_word(out_valid), '0);
		check_field("in_ready after reset", bit_word(in_ready), bit_word(1'b1));
		send_rows();
		wait (results_seen == ROWS);
		// room for a stray extra result
		repeat (50) @(posedge clk);
		$display("%0d errors in %0d checks, %0d results", errors, checks, results_seen);
		if (errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

	// random back-pressure, ready about three cycles in four
	initial
	begin
		seed      = 32'h2ef5;
		out_ready = 1'b0;
		forever
		begin
			@(posedge clk);
			out_ready <= ($random(seed) & 32'd3) != 32'd0;
		end
	end

	// outputs sampled mid-cycle
	always @(negedge clk)
	begin
		if (!CLK_d)
		begin
			if (holding)
				check_held();
			holding = out_valid && !out_ready;
			if (holding)
				hold_result();
			if (out_valid && out_ready)
				take_result();
		end
	end

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("timeout: not every result arrived within %0d cycles", WATCHDOG_CYCLES);
		$display("TEST FAILED");
		$finish;
	end

endmodule

/* verilog.f */
+incdir+.
collide_pkg.sv
stage_buffer.sv
sphere_separation.sv
contact_classify.sv
contact_normalize.sv
contact_point.sv
sphere_collide_top.sv
tb_sphere_collide.sv
